//--- source/ppd_params.svh
/*
 * Filter sizes, bus widths and register addresses
 */
`ifndef PPD_PARAMS_SVH
`define PPD_PARAMS_SVH

`define PPD_DECIM       4    // Phases per frame
`define PPD_COEFF_LEN   8    // Filter taps
`define PPD_COEFF_HALF  4    // Stored coefficients, symmetric taps
`define PPD_COLS        2    // Polyphase columns
`define PPD_IDATA_W     8
`define PPD_COEFF_W     12
`define PPD_ODATA_W     23   // Sample + coeff + tree and column growth

`define PPD_WB_AW       3
`define PPD_WB_DW       32

`define PPD_ADDR_CTRL   3'd0
`define PPD_ADDR_COUNT  3'd1
`define PPD_ADDR_COEFF0 3'd4

`endif

//--- source/ppd_dsp_pkg.sv
/*
 * Datapath types of the polyphase decimator
 * Samples, coefficients, frames, products and sums
 */
`include "ppd_params.svh"

package ppd_dsp_pkg;

  // ------------------------------
  // Input side
  // ------------------------------
  typedef logic signed [`PPD_IDATA_W-1:0] sample_t;
  typedef logic signed [`PPD_COEFF_W-1:0] coeff_t;

  // Index p holds the p-th sample of a frame
  typedef sample_t [`PPD_DECIM-1:0] frame_t;

  // ------------------------------
  // Arithmetic results
  // ------------------------------
  typedef logic signed [`PPD_IDATA_W+`PPD_COEFF_W-1:0] product_t;

  // One column of DECIM products
  typedef logic signed [`PPD_IDATA_W+`PPD_COEFF_W+$clog2(`PPD_DECIM)-1:0] colsum_t;

  // Full precision output, no rounding
  typedef logic signed [`PPD_ODATA_W-1:0] odata_t;

endpackage

//--- source/ppd_bus_pkg.sv
/*
 * Wishbone register map types, data word union and address enum
 */
`include "ppd_params.svh"

package ppd_bus_pkg;

  typedef logic [`PPD_WB_DW-1:0] wb_word_t;

  typedef struct packed {
    logic [`PPD_WB_DW-3:0] reserved;
    logic                  clear;    // Self clearing, reads zero
    logic                  enable;
  } ctrl_fields_t;

  typedef struct packed {
    logic [`PPD_WB_DW-`PPD_COEFF_W-1:0] pad;
    ppd_dsp_pkg::coeff_t                coeff;
  } coeff_fields_t;

  // Same word, decoded by address
  typedef union packed {
    wb_word_t      raw;
    ctrl_fields_t  ctrl_view;
    coeff_fields_t coeff_view;
  } wb_word_u;

  typedef enum logic [`PPD_WB_AW-1:0] {
    ADDR_CTRL   = `PPD_ADDR_CTRL,
    ADDR_COUNT  = `PPD_ADDR_COUNT,
    ADDR_COEFF0 = `PPD_ADDR_COEFF0,
    ADDR_COEFF1,
    ADDR_COEFF2,
    ADDR_COEFF3
  } wb_addr_e;

endpackage

//--- source/ppd_coeff_if.sv
/*
 * Coefficient write and clear path from control to multiplier-adder
 */
`timescale 1ns/10ps
`include "ppd_params.svh"

interface ppd_coeff_if;
  import ppd_dsp_pkg::*;

  logic                               wr_en;    // One cycle strobe
  logic [$clog2(`PPD_COEFF_HALF)-1:0] wr_idx;
  coeff_t                             wr_data;
  logic                               clear;    // One cycle strobe

  modport ctrl (
    output wr_en, wr_idx, wr_data, clear
  );

  modport mac (
    input wr_en, wr_idx, wr_data, clear
  );

endinterface

//--- source/ppd_ctrl.sv
/*
 * Wishbone classic slave: control register, output frame counter,
 * coefficient shadow and write forwarding
 */
`timescale 1ns/10ps
`include "ppd_params.svh"

module ppd_ctrl (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  ppd_bus_pkg::wb_addr_e i_wb_adr,
  input  ppd_bus_pkg::wb_word_u i_wb_dat,
  output ppd_bus_pkg::wb_word_t o_wb_dat,
  output logic                  o_wb_ack,
  input  logic                  i_out_valid,  // Counted output frames
  output logic                  o_enable,
  output logic                  o_clear,
  ppd_coeff_if.ctrl             coeff
);
  import ppd_bus_pkg::*;
  import ppd_dsp_pkg::*;

  localparam int IDX_W = $clog2(`PPD_COEFF_HALF);
  localparam int PAD_W = `PPD_WB_DW - `PPD_COEFF_W;

  logic                  req;
  logic                  wr_req;
  logic [IDX_W-1:0]      idx;
  coeff_t                shadow [`PPD_COEFF_HALF];  // Readback copy
  logic [`PPD_WB_DW-1:0] frame_cnt;
  wb_word_u              rd_word;
  logic                  enable_q;
  logic                  clear_q;
  logic                  wr_en_q;
  logic [IDX_W-1:0]      wr_idx_q;
  coeff_t                wr_data_q;

  assign req    = i_wb_cyc & i_wb_stb & ~o_wb_ack;  // No re-ack while stb still high
  assign wr_req = req & i_wb_we;
  assign idx    = i_wb_adr[IDX_W-1:0];               // COEFF0..3 sit at 4..7

  // Read mux
  always_comb
  begin
    rd_word = '0;
    case (i_wb_adr)
      ADDR_CTRL:  rd_word.ctrl_view.enable = enable_q;
      ADDR_COUNT: rd_word.raw = frame_cnt;
      ADDR_COEFF0, ADDR_COEFF1, ADDR_COEFF2, ADDR_COEFF3:
      begin
        rd_word.coeff_view.pad   = {PAD_W{shadow[idx][`PPD_COEFF_W-1]}};  // Sign extend
        rd_word.coeff_view.coeff = shadow[idx];
      end
      default: rd_word = '0;  // Holes at 2 and 3
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_wb_ack  <= 1'b0;
      enable_q  <= 1'b0;
      clear_q   <= 1'b0;
      wr_en_q   <= 1'b0;
      frame_cnt <= '0;
      shadow    <= '{default: '0};
    end
    else
    begin
      o_wb_ack <= req;
      clear_q  <= 1'b0;
      wr_en_q  <= 1'b0;
      if (i_out_valid)
        frame_cnt <= frame_cnt + 1'b1;  // Wraps
      if (wr_req)
      begin
        case (i_wb_adr)
          ADDR_CTRL:
          begin
            enable_q <= i_wb_dat.ctrl_view.enable;
            clear_q  <= i_wb_dat.ctrl_view.clear;
          end
          ADDR_COEFF0, ADDR_COEFF1, ADDR_COEFF2, ADDR_COEFF3:
          begin
            shadow[idx] <= i_wb_dat.coeff_view.coeff;
            wr_en_q     <= 1'b1;
          end
          default: wr_en_q <= 1'b0;  // Counter is read only
        endcase
      end
    end
  end

  // Payload, qualified by ack and wr_en
  always_ff @(posedge i_clk)
  begin
    if (req)
    begin
      o_wb_dat  <= rd_word.raw;
      wr_idx_q  <= idx;
      wr_data_q <= i_wb_dat.coeff_view.coeff;
    end
  end

  assign o_enable      = enable_q;
  assign o_clear       = clear_q;
  assign coeff.clear   = clear_q;
  assign coeff.wr_en   = wr_en_q;
  assign coeff.wr_idx  = wr_idx_q;
  assign coeff.wr_data = wr_data_q;

endmodule

//--- source/ppd_commutator.sv
/*
 * Serial to frame commutator, one strobe per DECIM accepted samples
 */
`timescale 1ns/10ps
`include "ppd_params.svh"

module ppd_commutator (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_enable,
  input  logic                 i_clear,
  input  logic                 i_valid,
  input  ppd_dsp_pkg::sample_t i_sample,
  output logic                 o_frame_stb,
  output ppd_dsp_pkg::frame_t  o_frame
);
  import ppd_dsp_pkg::*;

  localparam int              PH_W    = $clog2(`PPD_DECIM);
  localparam logic [PH_W-1:0] LAST_PH = PH_W'(`PPD_DECIM - 1);

  logic            take;
  logic            last;
  logic [PH_W-1:0] phase;       // Next slot to fill
  frame_t          slots;
  frame_t          next_frame;

  assign take = i_valid & i_enable & ~i_clear;  // Disabled samples dropped
  assign last = (phase == LAST_PH);

  always_comb
  begin
    next_frame        = slots;
    next_frame[phase] = i_sample;
  end

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      phase       <= '0;
      o_frame_stb <= 1'b0;
    end
    else
    begin
      o_frame_stb <= take & last;
      if (i_clear)
        phase <= '0;                             // Restart at slot 0
      else if (take)
        phase <= last ? '0 : phase + 1'b1;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (take)
    begin
      slots <= next_frame;
      if (last)
        o_frame <= next_frame;                   // Held until next frame
    end
  end

endmodule

//--- source/ppd_mul_add.sv
/*
 * Symmetric coefficient store and transposed-form polyphase multiply-add
 * with column pipeline and registered output
 */
`timescale 1ns/10ps
`include "ppd_params.svh"

module ppd_mul_add (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_frame_stb,
  input  ppd_dsp_pkg::frame_t i_frame,
  ppd_coeff_if.mac            coeff,
  output logic                o_valid,
  output ppd_dsp_pkg::odata_t o_data
);
  import ppd_dsp_pkg::*;

  coeff_t   c_half   [`PPD_COEFF_HALF];
  coeff_t   h        [`PPD_COEFF_LEN];   // Unfolded taps
  product_t prod     [`PPD_COEFF_LEN];
  colsum_t  col_sum  [`PPD_COLS];
  odata_t   col_acc  [`PPD_COLS];
  odata_t   col_pipe [`PPD_COLS-1];      // Column registers

  // ------------------------------
  // Taps and constant multipliers
  // ------------------------------
  genvar t;
  generate
    for (t = 0; t < `PPD_COEFF_LEN; t++)
    begin : g_tap
      if (t < `PPD_COEFF_HALF)
      begin : g_lo
        assign h[t] = c_half[t];
      end
      else
      begin : g_hi
        assign h[t] = c_half[`PPD_COEFF_LEN-1-t];  // Mirror
      end
      // Counter-clockwise, every column sees the same frame
      assign prod[t] = product_t'(i_frame[t % `PPD_DECIM]) * product_t'(h[t]);
    end
  endgenerate

  // ------------------------------
  // Column adders
  // ------------------------------
  always_comb
  begin
    for (int c = 0; c < `PPD_COLS; c++)
    begin
      col_sum[c] = '0;
      for (int p = 0; p < `PPD_DECIM; p++)
        col_sum[c] = col_sum[c] + colsum_t'(prod[c*`PPD_DECIM + p]);
    end
  end

  // Transposed chain, top column enters first
  always_comb
  begin
    col_acc[`PPD_COLS-1] = odata_t'(col_sum[`PPD_COLS-1]);
    for (int n = `PPD_COLS-2; n >= 0; n--)
      col_acc[n] = odata_t'(col_sum[n]) + col_pipe[n];
  end

  // ------------------------------
  // State
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_valid  <= 1'b0;
      c_half   <= '{default: '0};
      col_pipe <= '{default: '0};
    end
    else
    begin
      o_valid <= i_frame_stb;
      if (coeff.wr_en)
        c_half[coeff.wr_idx] <= coeff.wr_data;
      if (coeff.clear)
        col_pipe <= '{default: '0};        // Forget previous frames
      else if (i_frame_stb)
      begin
        for (int n = 0; n < `PPD_COLS-1; n++)
          col_pipe[n] <= col_acc[n+1];     // Advance one frame
      end
    end
  end

  // Full precision result, valid with o_valid
  always_ff @(posedge i_clk)
  begin
    if (i_frame_stb)
      o_data <= col_acc[0];
  end

endmodule

//--- source/ppd_top.sv
/*
 * Polyphase decimator top: control, commutator, multiplier-adder
 */
`timescale 1ns/10ps

module ppd_top (
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  // Wishbone slave
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  ppd_bus_pkg::wb_addr_e i_wb_adr,
  input  ppd_bus_pkg::wb_word_t i_wb_dat,
  output ppd_bus_pkg::wb_word_t o_wb_dat,
  output logic                  o_wb_ack,
  // Sample stream
  input  logic                  i_valid,
  input  ppd_dsp_pkg::sample_t  i_sample,
  // Result
  output logic                  o_valid,
  output ppd_dsp_pkg::odata_t   o_data
);
  import ppd_dsp_pkg::*;

  logic   enable;
  logic   clear;
  logic   frame_stb;
  frame_t frame;

  ppd_coeff_if coeff_bus ();

  ppd_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .i_out_valid (o_valid),
    .o_enable    (enable),
    .o_clear     (clear),
    .coeff       (coeff_bus.ctrl)
  );

  ppd_commutator u_commutator (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_enable    (enable),
    .i_clear     (clear),
    .i_valid     (i_valid),
    .i_sample    (i_sample),
    .o_frame_stb (frame_stb),
    .o_frame     (frame)
  );

  ppd_mul_add u_mul_add (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_frame_stb (frame_stb),
    .i_frame     (frame),
    .coeff       (coeff_bus.mac),
    .o_valid     (o_valid),
    .o_data      (o_data)
  );

endmodule

//--- verif/ppd_props.sv
/*
 * Concurrent checks on the Wishbone handshake and the output strobe
 */
`timescale 1ns/10ps
`include "ppd_params.svh"

module ppd_props (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_wb_cyc,
  input logic i_wb_stb,
  input logic i_wb_ack,
  input logic i_valid,
  input logic i_enable,
  input logic i_clear,
  input logic i_out_valid
);

  localparam int PH_W = $clog2(`PPD_DECIM);

  logic [PH_W-1:0] seen;         // Samples accepted in current frame
  logic            accept;
  logic            accept_last;

  assign accept      = i_valid & i_enable & ~i_clear;
  assign accept_last = accept & (seen == PH_W'(`PPD_DECIM - 1));

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      seen <= '0;
    else if (i_clear)
      seen <= '0;
    else if (accept)
      seen <= accept_last ? '0 : seen + 1'b1;
  end

  // ------------------------------
  // Wishbone
  // ------------------------------
  ack_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wb_ack |=> !i_wb_ack)
    else $error("ack high for two cycles");

  ack_after_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else $error("ack without a preceding strobe");

  // ------------------------------
  // Output strobe
  // ------------------------------
  valid_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_out_valid |=> !i_out_valid)
    else $error("o_valid longer than one cycle");

  valid_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    accept_last |=> ##1 i_out_valid)
    else $error("o_valid missing two cycles after last sample of a frame");

endmodule

bind ppd_top ppd_props u_props (
  .i_clk       (i_clk),
  .i_arst_n    (i_arst_n),
  .i_wb_cyc    (i_wb_cyc),
  .i_wb_stb    (i_wb_stb),
  .i_wb_ack    (o_wb_ack),
  .i_valid     (i_valid),
  .i_enable    (enable),
  .i_clear     (clear),
  .i_out_valid (o_valid)
);

//--- verif/ppd_tb.sv
/*
 * Testbench for ppd_top: Wishbone master tasks, random stimulus,
 * reference model of the polyphase decimator, compare tasks, watchdog
 */
`timescale 1ns/10ps
`include "ppd_params.svh"

module ppd_tb;
  import ppd_dsp_pkg::*;
  import ppd_bus_pkg::*;

  localparam int N_SAMPLES   = 12 + 200 + 20 + 14;  // Impulse, random, disabled, clear
  localparam int TIMEOUT_CYC = N_SAMPLES * 20 + 2000;

  logic     clk;
  logic     arst_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_e wb_adr;
  wb_word_t wb_dat_w;
  wb_word_t wb_dat_r;
  logic     wb_ack;
  logic     valid;
  sample_t  sample;
  logic     out_valid;
  odata_t   out_data;

  // Reference model state
  coeff_t   coef_m [`PPD_COEFF_HALF];
  sample_t  slot_m [`PPD_DECIM];
  int       phase_m;
  int       s1_prev_m;                  // Upper column sum of last frame
  int       frames_m;                   // Frames completed by the model
  logic     enable_m;
  odata_t   expect_q [$];

  int       errors;                     // Main process
  int       data_errors;                // Output monitor
  int       pulses;
  int       tests_run;
  int       tests_ok;

  ppd_top UUT (
    .i_clk    (clk),
    .i_arst_n (arst_n),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_dat_w),
    .o_wb_dat (wb_dat_r),
    .o_wb_ack (wb_ack),
    .i_valid  (valid),
    .i_sample (sample),
    .o_valid  (out_valid),
    .o_data   (out_data)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ------------------------------
  // Model and compare
  // ------------------------------
  function automatic coeff_t tap(int i);
    return (i < `PPD_COEFF_HALF) ? coef_m[i] : coef_m[`PPD_COEFF_LEN-1-i];
  endfunction

  task automatic model_accept(sample_t x);
    int s0;
    int s1;
    slot_m[phase_m] = x;
    if (phase_m == `PPD_DECIM - 1)
    begin
      s0 = 0;
      s1 = 0;
      for (int p = 0; p < `PPD_DECIM; p++)
      begin
        s0 += int'(slot_m[p]) * int'(tap(p));
        s1 += int'(slot_m[p]) * int'(tap(p + `PPD_DECIM));
      end
      expect_q.push_back(odata_t'(s0 + s1_prev_m));
      s1_prev_m = s1;
      phase_m   = 0;
      frames_m++;
    end
    else
      phase_m++;
  endtask

  task automatic check_odata(string name, odata_t got, odata_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_word(string name, wb_word_t got, wb_word_t exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ------------------------------
  // Bus and stream drivers
  // ------------------------------
  task automatic wb_access(wb_addr_e a, logic we, wb_word_t d, output wb_word_t q);
    int n;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = a;
    wb_dat_w = d;
    n = 0;
    @(posedge clk); #1;
    while (!wb_ack && n < 16)
    begin
      @(posedge clk); #1;
      n++;
    end
    if (!wb_ack)
    begin
      $display("Error: no Wishbone ack at address %0d", a);
      errors++;
    end
    q      = wb_dat_r;                  // Valid while ack is high
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk); #1;                 // Let a pending clear take effect
  endtask

  task automatic send_sample(sample_t x, int gap);
    valid  = 1'b1;
    sample = x;
    if (enable_m)
      model_accept(x);
    @(posedge clk); #1;
    valid = 1'b0;
    repeat (gap)
    begin
      @(posedge clk); #1;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (expect_q.size() != 0 && n < 200)
    begin
      @(posedge clk); #1;
      n++;
    end
    if (expect_q.size() != 0)
    begin
      $display("Error: %0d expected outputs never appeared", expect_q.size());
      errors++;
    end
    repeat (4) @(posedge clk);          // Catch stray strobes
    #1;
  endtask

  task automatic end_test(string name, int err_before);
    tests_run++;
    if (errors + data_errors == err_before)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
      $display("test %s: %0d errors", name, errors + data_errors - err_before);
  endtask

  // Output monitor, sampled away from the active edge
  always @(negedge clk)
  begin
    if (arst_n && out_valid)
    begin
      pulses++;
      if (expect_q.size() == 0)
      begin
        $display("Error: o_valid seen with no output expected");
        data_errors++;
      end
      else
        check_odata("o_data", out_data, expect_q.pop_front());
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("tests failed");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    int       e0;
    int       p0;
    wb_word_t rd;
    wb_word_t exp;
    wb_word_u w;
    void'($urandom(32'h9914));
    arst_n      = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = ADDR_CTRL;
    wb_dat_w    = '0;
    valid       = 1'b0;
    sample      = '0;
    phase_m     = 0;
    s1_prev_m   = 0;
    frames_m    = 0;
    enable_m    = 1'b0;
    coef_m      = '{default: '0};
    errors      = 0;
    data_errors = 0;
    pulses      = 0;
    tests_run   = 0;
    tests_ok    = 0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;

    // Register access, pad bits of the write are random
    e0 = errors + data_errors;
    for (int i = 0; i < `PPD_COEFF_HALF; i++)
    begin
      coef_m[i]          = coeff_t'($urandom);
      w.raw              = $urandom;
      w.coeff_view.coeff = coef_m[i];
      wb_access(wb_addr_e'(`PPD_ADDR_COEFF0 + i), 1'b1, w.raw, rd);
    end
    for (int i = 0; i < `PPD_COEFF_HALF; i++)
    begin
      exp = {{(`PPD_WB_DW-`PPD_COEFF_W){coef_m[i][`PPD_COEFF_W-1]}}, coef_m[i]};
      wb_access(wb_addr_e'(`PPD_ADDR_COEFF0 + i), 1'b0, '0, rd);
      check_word("coeff", rd, exp);
    end
    // Clear on an empty filter changes nothing but must read back as zero
    w.raw              = $urandom;
    w.ctrl_view.clear  = 1'b1;
    w.ctrl_view.enable = 1'b1;
    wb_access(ADDR_CTRL, 1'b1, w.raw, rd);
    enable_m = 1'b1;
    wb_access(ADDR_CTRL, 1'b0, '0, rd);
    check_word("ctrl", rd, 32'h1);
    wb_access(wb_addr_e'(3'd2), 1'b0, '0, rd);
    check_word("hole", rd, '0);
    end_test("1 register access", e0);

    // Impulse in slot 0, then zero frames give h[0], h[4], 0
    e0 = errors + data_errors;
    send_sample(sample_t'(1), 0);
    repeat (11) send_sample(sample_t'(0), 0);
    wait_drain();
    end_test("2 impulse", e0);

    e0 = errors + data_errors;
    p0 = pulses;
    repeat (200) send_sample(sample_t'($urandom), int'($urandom_range(3, 0)));
    wait_drain();
    if (pulses - p0 != 50)
    begin
      $display("Error: random stream gave %0d outputs instead of 50", pulses - p0);
      errors++;
    end
    end_test("3 random stream", e0);

    // Disabled samples are dropped
    e0 = errors + data_errors;
    wb_access(ADDR_CTRL, 1'b1, 32'h0, rd);
    enable_m = 1'b0;
    p0 = pulses;
    repeat (20) send_sample(sample_t'($urandom), int'($urandom_range(2, 0)));
    wait_drain();
    if (pulses != p0)
    begin
      $display("Error: %0d outputs while the filter was disabled", pulses - p0);
      errors++;
    end
    end_test("4 enable low", e0);

    // Clear in the middle of a frame
    e0 = errors + data_errors;
    wb_access(ADDR_CTRL, 1'b1, 32'h1, rd);
    enable_m = 1'b1;
    repeat (2) send_sample(sample_t'($urandom), 0);
    wb_access(ADDR_CTRL, 1'b1, 32'h3, rd);
    phase_m   = 0;
    s1_prev_m = 0;
    repeat (12) send_sample(sample_t'($urandom), int'($urandom_range(3, 0)));
    wait_drain();
    end_test("5 clear", e0);

    e0 = errors + data_errors;
    wb_access(ADDR_COUNT, 1'b0, '0, rd);
    check_word("count", rd, wb_word_t'(frames_m));
    end_test("6 frame counter", e0);

    $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors + data_errors);
    if (errors + data_errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+source
source/ppd_dsp_pkg.sv
source/ppd_bus_pkg.sv
source/ppd_coeff_if.sv
source/ppd_ctrl.sv
source/ppd_commutator.sv
source/ppd_mul_add.sv
source/ppd_top.sv
verif/ppd_props.sv
verif/ppd_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run ppd_tb with Verilator, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module ppd_tb -f verilog.f -o ppd_sim \
  > build.log 2>&1 || { cat build.log; echo "FAIL: build error"; exit 1; }
./obj_dir/ppd_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "simulator exited with an error" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
